//--- hdl/fb_pkg.sv
`default_nettype none

package fb_pkg;

	localparam int PIX_W      = 16;  // one rgb565 pixel
	localparam int BURST_LEN  = 16;  // words per sdram burst
	localparam int FRAME_ROWS = 8;   // bursts per frame
	localparam int FIFO_DEPTH = 64;  // entries per pixel fifo
	localparam int LVL_W      = 7;   // fill level, 0..FIFO_DEPTH
	localparam int ROW_W      = 3;   // row address width
	localparam int CNT_W      = $clog2(BURST_LEN + 1);  // burst word counter

	typedef logic [1:0] bank_t;  // sdram bank number

	// sdram command opcodes
	typedef enum logic {
		MEM_WRITE = 1'b0,
		MEM_READ  = 1'b1
	} mem_op_e;

	// burst scheduler states
	typedef enum logic [1:0] {
		S_IDLE    = 2'd0,  // waiting for a fifo to reach a burst
		S_CMD     = 2'd1,  // command offered to controller
		S_WR_DATA = 2'd2,  // streaming write burst out
		S_RD_DATA = 2'd3   // collecting read burst
	} sched_state_e;

	// camera byte bus
	typedef struct packed {
		logic       vsync;
		logic       href;
		logic [7:0] data;
	} cam_bus_t;

	// command to sdram controller
	typedef struct packed {
		mem_op_e          op;
		bank_t            bank;
		logic [ROW_W-1:0] row;
	} mem_cmd_t;

	typedef struct packed {
		bank_t cam_bank;  // bank being filled by camera
		bank_t vga_bank;  // bank being shown
	} bank_sel_t;

endpackage

`default_nettype wire

//--- hdl/cam_byte_pack.sv
`timescale 1ns/1ps
`default_nettype none

module cam_byte_pack (
	input  wire logic                     clk_133M,
	input  wire logic                     rst_133,
	input  wire fb_pkg::cam_bus_t         cam_i,
	input  wire logic                     cam_valid_i,
	output logic [fb_pkg::PIX_W-1:0]      pix_o,
	output logic                          pix_valid_o
);
	import fb_pkg::*;

	logic                 vsync_d;   // vsync of previous cycle
	logic                 vs_rise;
	logic                 take;      // byte accepted this cycle
	logic                 phase;     // 1 = high byte held, waiting for low
	logic [PIX_W/2-1:0]   hi_byte;

	assign vs_rise = cam_i.vsync && !vsync_d;
	assign take    = cam_valid_i && cam_i.href;

	// byte phase and frame sync edge
	always_ff @(posedge clk_133M or negedge rst_133) begin
		if (!rst_133) begin
			vsync_d     <= 1'b0;
			phase       <= 1'b0;
			pix_valid_o <= 1'b0;
		end else begin
			vsync_d     <= cam_i.vsync;
			pix_valid_o <= take && phase && !vs_rise;  // pixel done on low byte
			if (take) begin
				// a byte on the sync edge itself starts a new pair
				phase <= vs_rise ? 1'b1 : !phase;
			end else if (vs_rise) begin
				phase <= 1'b0;  // realign, next byte is high
			end
		end
	end

	// byte pair assembly
	always_ff @(posedge clk_133M) begin
		if (take && (vs_rise || !phase)) begin
			hi_byte <= cam_i.data;  // high byte first
		end
		if (take && phase && !vs_rise) begin
			pix_o <= {hi_byte, cam_i.data};
		end
	end

endmodule

`default_nettype wire

//--- hdl/pixel_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_fifo #(
	parameter int DEPTH = fb_pkg::FIFO_DEPTH  // power of two
) (
	input  wire logic                     clk_133M,
	input  wire logic                     rst_133,
	input  wire logic                     clear_i,
	input  wire logic                     push_i,
	input  wire logic [fb_pkg::PIX_W-1:0] din_i,
	input  wire logic                     pop_i,
	output logic [fb_pkg::PIX_W-1:0]      dout_o,
	output logic                          empty_o,
	output logic [fb_pkg::LVL_W-1:0]      level_o
);
	import fb_pkg::*;

	logic [PIX_W-1:0]           mem [DEPTH];
	logic [$clog2(DEPTH)-1:0]   wr_ptr;
	logic [$clog2(DEPTH)-1:0]   rd_ptr;
	logic [LVL_W-1:0]           count;
	logic                       full;
	logic                       do_push;
	logic                       do_pop;

	assign full    = (count == LVL_W'(DEPTH));
	assign empty_o = (count == '0);
	assign level_o = count;
	assign dout_o  = mem[rd_ptr];  // show-ahead read

	assign do_pop  = pop_i && !empty_o;
	assign do_push = push_i && (!full || do_pop);  // full slot frees on same-cycle pop

	always_ff @(posedge clk_133M) begin
		if (do_push) begin
			mem[wr_ptr] <= din_i;
		end
	end

	// pointers wrap naturally at DEPTH
	always_ff @(posedge clk_133M or negedge rst_133) begin
		if (!rst_133) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else if (clear_i) begin
			wr_ptr <= '0;  // drop everything
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			if (do_push && !do_pop) begin
				count <= count + 1'b1;
			end else if (do_pop && !do_push) begin
				count <= count - 1'b1;
			end
		end
	end

	// camera side cannot stall, so overflow means the scheduler fell behind
	a_no_overflow: assert property (@(posedge clk_133M) disable iff (!rst_133)
		!clear_i && push_i && full |-> pop_i);

	a_no_underflow: assert property (@(posedge clk_133M) disable iff (!rst_133)
		!clear_i && pop_i |-> !empty_o);

endmodule

`default_nettype wire

//--- hdl/bank_rotator.sv
`timescale 1ns/1ps
`default_nettype none

module bank_rotator (
	input  wire logic            clk_133M,
	input  wire logic            rst_133,
	input  wire logic            cam_frame_done_i,
	input  wire logic            vga_frame_start_i,
	output fb_pkg::bank_sel_t    banks_o
);
	import fb_pkg::*;

	bank_t cam_bank;
	bank_t vga_bank;
	bank_t free_bank;  // last complete frame or spare
	logic  fresh;      // free bank holds a frame not yet shown

	always_ff @(posedge clk_133M or negedge rst_133) begin
		if (!rst_133) begin
			cam_bank  <= 2'd1;
			vga_bank  <= 2'd0;
			free_bank <= 2'd2;
			fresh     <= 1'b0;
		end else begin
			if (cam_frame_done_i && vga_frame_start_i) begin
				// both at once: display jumps straight to the frame just finished
				vga_bank  <= cam_bank;
				cam_bank  <= free_bank;
				free_bank <= vga_bank;
				fresh     <= 1'b0;
			end else if (cam_frame_done_i) begin
				cam_bank  <= free_bank;  // camera takes spare
				free_bank <= cam_bank;   // finished frame parked
				fresh     <= 1'b1;
			end else if (vga_frame_start_i && fresh) begin
				vga_bank  <= free_bank;  // show parked frame
				free_bank <= vga_bank;
				fresh     <= 1'b0;
			end
			// start without a fresh frame repeats the old one
		end
	end

	always_comb begin
		banks_o.cam_bank = cam_bank;
		banks_o.vga_bank = vga_bank;
	end

	// a bank is never shared between camera, display and spare
	a_banks_distinct: assert property (@(posedge clk_133M) disable iff (!rst_133)
		cam_bank != vga_bank && cam_bank != free_bank && vga_bank != free_bank);

endmodule

`default_nettype wire

//--- hdl/burst_scheduler.sv
`timescale 1ns/1ps
`default_nettype none

module burst_scheduler (
	input  wire logic                     clk_133M,
	input  wire logic                     rst_133,
	input  wire logic [fb_pkg::LVL_W-1:0] wr_level_i,
	input  wire logic [fb_pkg::PIX_W-1:0] wr_fifo_data_i,
	output logic                          wr_pop_o,
	input  wire logic [fb_pkg::LVL_W-1:0] rd_free_i,
	output logic                          rd_push_o,
	output logic                          rd_clear_o,
	input  wire fb_pkg::bank_sel_t        banks_i,
	output fb_pkg::mem_cmd_t              cmd_o,
	output logic                          cmd_valid_o,
	input  wire logic                     cmd_ready_i,
	output logic [fb_pkg::PIX_W-1:0]      wr_data_o,
	output logic                          wr_valid_o,
	input  wire logic                     wr_ready_i,
	input  wire logic                     rd_valid_i,
	input  wire logic                     frame_start_i,
	output logic                          cam_frame_done_o,
	output logic                          vga_frame_start_o
);
	import fb_pkg::*;

	sched_state_e       state;
	mem_op_e            cmd_op;         // op of the outstanding command
	logic [CNT_W-1:0]   word_cnt;
	logic [CNT_W-1:0]   word_nxt;
	logic [ROW_W-1:0]   wr_row;
	logic [ROW_W-1:0]   rd_row;
	logic               rd_frame_done;  // every row of the display frame read
	logic               fs_pend;        // frame start waiting for read to finish
	logic               fs_req;
	logic               fs_serve;
	logic               rd_busy;
	logic               wr_go;
	logic               rd_go;
	logic               word_beat;
	logic               burst_last;

	assign cmd_valid_o = (state == S_CMD);
	assign wr_valid_o  = (state == S_WR_DATA);
	assign wr_data_o   = wr_fifo_data_i;          // fifo head, popped on handshake
	assign wr_pop_o    = wr_valid_o && wr_ready_i;
	assign rd_push_o   = (state == S_RD_DATA) && rd_valid_i;

	// bank and row only move between commands, so cmd_o holds while stalled
	always_comb begin
		cmd_o.op   = cmd_op;
		cmd_o.bank = (cmd_op == MEM_WRITE) ? banks_i.cam_bank : banks_i.vga_bank;
		cmd_o.row  = (cmd_op == MEM_WRITE) ? wr_row : rd_row;
	end

	assign rd_busy    = (state == S_RD_DATA) || (state == S_CMD && cmd_op == MEM_READ);
	assign fs_req     = fs_pend || frame_start_i;
	assign fs_serve   = fs_req && !rd_busy;
	assign wr_go      = (wr_level_i >= LVL_W'(BURST_LEN));
	assign rd_go      = (rd_free_i >= LVL_W'(BURST_LEN)) && !rd_frame_done && !fs_req;
	assign word_beat  = wr_pop_o || rd_push_o;
	assign word_nxt   = word_cnt + 1'b1;
	assign burst_last = word_beat && (word_nxt == CNT_W'(BURST_LEN));

	always_ff @(posedge clk_133M or negedge rst_133) begin
		if (!rst_133) begin
			state             <= S_IDLE;
			cmd_op            <= MEM_WRITE;
			word_cnt          <= '0;
			wr_row            <= '0;
			rd_row            <= '0;
			rd_frame_done     <= 1'b1;  // no reads before first display frame
			fs_pend           <= 1'b0;
			rd_clear_o        <= 1'b0;
			cam_frame_done_o  <= 1'b0;
			vga_frame_start_o <= 1'b0;
		end else begin
			cam_frame_done_o  <= 1'b0;
			vga_frame_start_o <= fs_serve;
			rd_clear_o        <= fs_serve;  // drop leftovers of last frame
			fs_pend           <= fs_req && !fs_serve;
			if (fs_serve) begin
				rd_row        <= '0;
				rd_frame_done <= 1'b0;
			end
			if (word_beat) begin
				word_cnt <= burst_last ? '0 : word_nxt;
			end
			case (state)
				S_IDLE: begin
					if (wr_go) begin  // writes first, camera cannot wait
						cmd_op <= MEM_WRITE;
						state  <= S_CMD;
					end else if (rd_go) begin
						cmd_op <= MEM_READ;
						state  <= S_CMD;
					end
				end
				S_CMD: begin
					if (cmd_ready_i) begin
						state <= (cmd_op == MEM_WRITE) ? S_WR_DATA : S_RD_DATA;
					end
				end
				S_WR_DATA: begin
					if (burst_last) begin
						state <= S_IDLE;
						if (wr_row == ROW_W'(FRAME_ROWS - 1)) begin
							wr_row           <= '0;
							cam_frame_done_o <= 1'b1;  // whole frame in sdram
						end else begin
							wr_row <= wr_row + 1'b1;
						end
					end
				end
				S_RD_DATA: begin
					if (burst_last) begin
						state <= S_IDLE;
						if (rd_row == ROW_W'(FRAME_ROWS - 1)) begin
							rd_frame_done <= 1'b1;  // wait for next frame start
						end else begin
							rd_row <= rd_row + 1'b1;
						end
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// bank comes from the rotator, row from the counters
	a_cmd_hold: assert property (@(posedge clk_133M) disable iff (!rst_133)
		cmd_valid_o && !cmd_ready_i |=> cmd_valid_o && $stable(cmd_o));

endmodule

`default_nettype wire

//--- hdl/frame_buffer_top.sv
`timescale 1ns/1ps
`default_nettype none

module frame_buffer_top (
	input  wire logic                     clk_133M,
	input  wire logic                     rst_133,
	// camera
	input  wire fb_pkg::cam_bus_t         cam_i,
	input  wire logic                     cam_valid_i,
	// sdram controller command port
	output fb_pkg::mem_cmd_t              cmd_o,
	output logic                          cmd_valid_o,
	input  wire logic                     cmd_ready_i,
	// burst data
	output logic [fb_pkg::PIX_W-1:0]      wr_data_o,
	output logic                          wr_valid_o,
	input  wire logic                     wr_ready_i,
	input  wire logic [fb_pkg::PIX_W-1:0] rd_data_i,
	input  wire logic                     rd_valid_i,
	// display
	input  wire logic                     frame_start_i,
	output logic [fb_pkg::PIX_W-1:0]      pix_o,
	output logic                          pix_valid_o,
	input  wire logic                     pix_ready_i
);
	import fb_pkg::*;

	logic [PIX_W-1:0]   cam_pix;
	logic               cam_pix_valid;
	logic [PIX_W-1:0]   wr_fifo_dout;
	logic               wr_fifo_pop;
	logic [LVL_W-1:0]   wr_level;
	logic               rd_push;
	logic               rd_clear;
	logic               rd_pop;
	logic               rd_empty;
	logic [LVL_W-1:0]   rd_level;
	logic [LVL_W-1:0]   rd_free;
	logic               cam_frame_done;
	logic               vga_frame_start;
	bank_sel_t          banks;

	assign rd_free     = LVL_W'(FIFO_DEPTH) - rd_level;  // room for read bursts
	assign pix_valid_o = !rd_empty;
	assign rd_pop      = pix_valid_o && pix_ready_i;

	cam_byte_pack cam_byte_pack_i (
		.clk_133M    (clk_133M),
		.rst_133     (rst_133),
		.cam_i       (cam_i),
		.cam_valid_i (cam_valid_i),
		.pix_o       (cam_pix),
		.pix_valid_o (cam_pix_valid)
	);

	// camera pixels waiting for a write burst
	pixel_fifo #(.DEPTH(FIFO_DEPTH)) wr_fifo (
		.clk_133M (clk_133M),
		.rst_133  (rst_133),
		.clear_i  (1'b0),
		.push_i   (cam_pix_valid),
		.din_i    (cam_pix),
		.pop_i    (wr_fifo_pop),
		.dout_o   (wr_fifo_dout),
		.empty_o  (),            // level is enough for burst decisions
		.level_o  (wr_level)
	);

	// display pixels, cleared at each display frame start
	pixel_fifo #(.DEPTH(FIFO_DEPTH)) rd_fifo (
		.clk_133M (clk_133M),
		.rst_133  (rst_133),
		.clear_i  (rd_clear),
		.push_i   (rd_push),
		.din_i    (rd_data_i),
		.pop_i    (rd_pop),
		.dout_o   (pix_o),
		.empty_o  (rd_empty),
		.level_o  (rd_level)
	);

	burst_scheduler burst_scheduler_i (
		.clk_133M          (clk_133M),
		.rst_133           (rst_133),
		.wr_level_i        (wr_level),
		.wr_fifo_data_i    (wr_fifo_dout),
		.wr_pop_o          (wr_fifo_pop),
		.rd_free_i         (rd_free),
		.rd_push_o         (rd_push),
		.rd_clear_o        (rd_clear),
		.banks_i           (banks),
		.cmd_o             (cmd_o),
		.cmd_valid_o       (cmd_valid_o),
		.cmd_ready_i       (cmd_ready_i),
		.wr_data_o         (wr_data_o),
		.wr_valid_o        (wr_valid_o),
		.wr_ready_i        (wr_ready_i),
		.rd_valid_i        (rd_valid_i),
		.frame_start_i     (frame_start_i),
		.cam_frame_done_o  (cam_frame_done),
		.vga_frame_start_o (vga_frame_start)
	);

	bank_rotator bank_rotator_i (
		.clk_133M          (clk_133M),
		.rst_133           (rst_133),
		.cam_frame_done_i  (cam_frame_done),
		.vga_frame_start_i (vga_frame_start),
		.banks_o           (banks)
	);

endmodule

`default_nettype wire

//--- test/sdram_burst_model.sv
`timescale 1ns/1ps
`default_nettype none

module sdram_burst_model (
	input  wire logic                     clk_133M,
	input  wire logic                     rst_133,
	input  wire fb_pkg::mem_cmd_t         cmd_i,
	input  wire logic                     cmd_valid_i,
	output logic                          cmd_ready_o,
	input  wire logic [fb_pkg::PIX_W-1:0] wr_data_i,
	input  wire logic                     wr_valid_i,
	output logic                          wr_ready_o,
	output logic [fb_pkg::PIX_W-1:0]      rd_data_o,
	output logic                          rd_valid_o
);
	import fb_pkg::*;

	localparam int COL_W  = $clog2(BURST_LEN);
	localparam int ADDR_W = 2 + ROW_W + COL_W;  // bank, row, column

	logic [PIX_W-1:0]  mem [2**ADDR_W];
	logic [ADDR_W-1:0] wr_addr;
	logic [ADDR_W-1:0] rd_addr;
	int                rd_left;   // read words still owed
	int                rd_wait;   // access latency before first word
	logic              cmd_beat;
	logic              wr_beat;

	assign cmd_beat = cmd_valid_i && cmd_ready_o;
	assign wr_beat  = wr_valid_i && wr_ready_o;

	always_ff @(posedge clk_133M) begin
		if (wr_beat) begin
			mem[wr_addr] <= wr_data_i;
		end
	end

	// random stalls on every handshake, data returned in burst order
	always_ff @(posedge clk_133M or negedge rst_133) begin
		if (!rst_133) begin
			cmd_ready_o <= 1'b0;
			wr_ready_o  <= 1'b0;
			rd_valid_o  <= 1'b0;
			rd_data_o   <= '0;
			wr_addr     <= '0;
			rd_addr     <= '0;
			rd_left     <= 0;
			rd_wait     <= 0;
		end else begin
			cmd_ready_o <= ($urandom_range(0, 3) != 0);  // stall 1 in 4
			wr_ready_o  <= ($urandom_range(0, 3) != 0);
			rd_valid_o  <= 1'b0;
			if (cmd_beat && cmd_i.op == MEM_WRITE) begin
				wr_addr <= {cmd_i.bank, cmd_i.row, COL_W'(0)};
			end else if (cmd_beat) begin
				rd_addr <= {cmd_i.bank, cmd_i.row, COL_W'(0)};
				rd_left <= BURST_LEN;
				rd_wait <= $urandom_range(0, 7);  // cas latency plus refresh jitter
			end
			if (wr_beat) begin
				wr_addr <= wr_addr + 1'b1;
			end
			if (rd_left > 0 && rd_wait > 0) begin
				rd_wait <= rd_wait - 1;
			end else if (rd_left > 0 && $urandom_range(0, 3) != 0) begin
				rd_valid_o <= 1'b1;  // gaps inside the burst too
				rd_data_o  <= mem[rd_addr];
				rd_addr    <= rd_addr + 1'b1;
				rd_left    <= rd_left - 1;
			end
		end
	end

endmodule

`default_nettype wire

//--- test/tb_frame_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module tb_frame_buffer;
	import fb_pkg::*;

	localparam int NUM_FRAMES    = 10;
	localparam int PIX_PER_FRAME = FRAME_ROWS * BURST_LEN;
	localparam int CLK_PERIOD    = 8;
	localparam int CAM_FRAME_CYC = PIX_PER_FRAME * 2 * 4 + 16;  // worst byte gaps + vsync
	localparam int TIMEOUT_CYC   = 12 * CAM_FRAME_CYC * 4;

	logic             clk_133M;
	logic             rst_133;
	cam_bus_t         cam_i;
	logic             cam_valid_i;
	mem_cmd_t         cmd_o;
	logic             cmd_valid_o;
	logic             cmd_ready_i;
	logic [PIX_W-1:0] wr_data_o;
	logic             wr_valid_o;
	logic             wr_ready_i;
	logic [PIX_W-1:0] rd_data_i;
	logic             rd_valid_i;
	logic             frame_start_i;
	logic [PIX_W-1:0] pix_o;
	logic             pix_valid_o;
	logic             pix_ready_i;

	int unsigned seed;
	int unsigned rnd;
	int          errors = 0;
	int          checks = 0;
	int          cam_bytes = 0;
	int          wr_cmds = 0;
	int          wr_words = 0;
	int          frames_done = 0;    // camera frames fully in sdram
	int          fs_floor = -1;      // newest finished frame at last display start
	int          last_exp = -1;
	int          pix_idx = 0;
	int          cur_exp = -1;
	int          rd_words = 0;
	int          bank_frame [4];     // frame held by each bank, -1 if none or partial
	int          exp_q [$];          // frame expected per display frame
	int          f;
	int          idx;
	int          e;
	bank_t       wr_bank;
	bank_t       disp_bank;
	logic        disp_active = 1'b0; // display bank still being read
	logic        cmd_seen = 1'b0;
	logic        seen_cmd = 1'b0;    // first command seen, for the display task
	int          disp_done = 0;
	int          shown_frame = -1;

	frame_buffer_top frame_buffer_top_i (
		.clk_133M      (clk_133M),
		.rst_133       (rst_133),
		.cam_i         (cam_i),
		.cam_valid_i   (cam_valid_i),
		.cmd_o         (cmd_o),
		.cmd_valid_o   (cmd_valid_o),
		.cmd_ready_i   (cmd_ready_i),
		.wr_data_o     (wr_data_o),
		.wr_valid_o    (wr_valid_o),
		.wr_ready_i    (wr_ready_i),
		.rd_data_i     (rd_data_i),
		.rd_valid_i    (rd_valid_i),
		.frame_start_i (frame_start_i),
		.pix_o         (pix_o),
		.pix_valid_o   (pix_valid_o),
		.pix_ready_i   (pix_ready_i)
	);

	sdram_burst_model sdram_burst_model_i (
		.clk_133M    (clk_133M),
		.rst_133     (rst_133),
		.cmd_i       (cmd_o),
		.cmd_valid_i (cmd_valid_o),
		.cmd_ready_o (cmd_ready_i),
		.wr_data_i   (wr_data_o),
		.wr_valid_i  (wr_valid_o),
		.wr_ready_o  (wr_ready_i),
		.rd_data_o   (rd_data_i),
		.rd_valid_o  (rd_valid_i)
	);

	// high byte frame number, low byte pixel index
	function automatic logic [PIX_W-1:0] ref_pixel(input int frame, input int index);
		return {8'(frame), 8'(index)};
	endfunction

	task automatic report_mismatch(input string what, input logic [PIX_W-1:0] got,
			input logic [PIX_W-1:0] want);
		errors++;
		$display("[FAIL] %0t ns: %s, got %h expected %h", $time, what, got, want);
	endtask

	task automatic report_error(input string what);
		errors++;
		$display("error at %0t ns: %s", $time, what);
	endtask

	task automatic send_byte(input logic [7:0] b);
		int gap;
		gap = $urandom_range(0, 3);
		repeat (gap) begin
			@(posedge clk_133M);
			cam_valid_i <= 1'b0;
		end
		@(posedge clk_133M);
		cam_i       <= {1'b0, 1'b1, b};  // vsync low, href high
		cam_valid_i <= 1'b1;
	endtask

	task automatic pulse_vsync();
		@(posedge clk_133M);
		cam_valid_i <= 1'b0;
		cam_i       <= {1'b1, 1'b0, 8'h00};
		repeat (4) @(posedge clk_133M);
		cam_i <= '0;
		repeat (4) @(posedge clk_133M);
	endtask

	task automatic run_camera();
		for (int fr = 0; fr < NUM_FRAMES; fr++) begin
			pulse_vsync();
			for (int i = 0; i < PIX_PER_FRAME; i++) begin
				send_byte(8'(fr));
				send_byte(8'(i));
			end
			if (fr % 2 == 1) begin
				send_byte(8'hee);  // dangling byte, next vsync realigns
			end
		end
		@(posedge clk_133M);
		cam_valid_i <= 1'b0;
		cam_i       <= '0;
	endtask

	// one display frame at a time, fully drained before the next start
	task automatic run_display();
		int target;
		while (!seen_cmd) @(posedge clk_133M);
		while (shown_frame != NUM_FRAMES - 1) begin
			repeat (200 + $urandom_range(0, 63)) @(posedge clk_133M);
			frame_start_i <= 1'b1;
			@(posedge clk_133M);
			frame_start_i <= 1'b0;
			target = disp_done + 1;
			while (disp_done < target) @(posedge clk_133M);
		end
	endtask

	initial begin
		clk_133M = 1'b0;
		forever #(CLK_PERIOD / 2) clk_133M = ~clk_133M;
	end

	always @(posedge clk_133M) begin
		pix_ready_i <= ($urandom_range(0, 1) == 1);  // display stalls half the time
	end

	// compare everything seen on the ports against the reference
	always @(posedge clk_133M) begin
		if (rst_133) begin
			if (cam_valid_i && cam_i.href) begin
				cam_bytes++;
			end
			if (!cmd_seen) begin
				checks++;
				if (cmd_valid_o && cam_bytes < 2 * BURST_LEN) begin
					report_error("command raised before a full burst was packed");
				end
				if (wr_valid_o || pix_valid_o) begin
					report_error("data valid before any command");
				end
			end
			if (cmd_valid_o) begin
				cmd_seen = 1'b1;
				seen_cmd <= 1'b1;
			end
			if (cmd_valid_o && cmd_ready_i && cmd_o.op == MEM_WRITE) begin
				checks++;
				if (cmd_o.row != ROW_W'(wr_cmds % FRAME_ROWS)) begin
					report_mismatch("write row", PIX_W'(cmd_o.row),
						PIX_W'(wr_cmds % FRAME_ROWS));
				end
				if (disp_active && cmd_o.bank == disp_bank) begin
					report_error("write targets the bank being displayed");
				end
				wr_bank = cmd_o.bank;
				if (cmd_o.row == '0) begin
					bank_frame[cmd_o.bank] = -1;  // old contents being overwritten
				end
				wr_cmds++;
			end else if (cmd_valid_o && cmd_ready_i && cmd_o.row == '0) begin
				e = bank_frame[cmd_o.bank];
				checks++;
				if (e < fs_floor) begin
					report_error($sformatf("display shows frame %0d, newer frame %0d was ready",
						e, fs_floor));
				end
				if (e >= 0 && e < last_exp) begin
					report_error("display frame number went backwards");
				end
				if (e >= 0) begin
					last_exp = e;
				end
				exp_q.push_back(e);
				disp_bank   = cmd_o.bank;
				disp_active = 1'b1;
				rd_words    = 0;
			end
			if (wr_valid_o && wr_ready_i) begin
				f   = wr_words / PIX_PER_FRAME;
				idx = wr_words % PIX_PER_FRAME;
				checks++;
				if (wr_data_o !== ref_pixel(f, idx)) begin
					report_mismatch("stored word", wr_data_o, ref_pixel(f, idx));
				end
				wr_words++;
				if (idx == PIX_PER_FRAME - 1) begin
					bank_frame[wr_bank] = f;  // frame complete in this bank
					frames_done         = f + 1;
				end
			end
			if (rd_valid_i) begin
				rd_words++;
				if (rd_words == PIX_PER_FRAME) begin
					disp_active = 1'b0;
				end
			end
			if (frame_start_i) begin
				fs_floor = frames_done - 1;  // includes a frame finishing this cycle
			end
			if (pix_valid_o && pix_ready_i) begin
				if (pix_idx == 0 && exp_q.size() == 0) begin
					report_error("display pixel without a display frame read");
					cur_exp = -1;
				end else if (pix_idx == 0) begin
					cur_exp = exp_q.pop_front();
				end
				if (cur_exp >= 0) begin
					checks++;
					if (pix_o !== ref_pixel(cur_exp, pix_idx)) begin
						report_mismatch("display pixel", pix_o, ref_pixel(cur_exp, pix_idx));
					end
				end
				pix_idx++;
				if (pix_idx == PIX_PER_FRAME) begin
					pix_idx = 0;
					disp_done   <= disp_done + 1;
					shown_frame <= cur_exp;
				end
			end
		end
	end

	initial begin
		#(TIMEOUT_CYC * CLK_PERIOD);
		$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYC);
		$display("CHECKS FAILED");
		$finish;
	end

	initial begin
		seed          = 32'h39be_7f5b;
		rnd           = $urandom(seed);
		rst_133       = 1'b0;
		cam_i         = '0;
		cam_valid_i   = 1'b0;
		frame_start_i = 1'b0;
		pix_ready_i   = 1'b0;
		foreach (bank_frame[b]) begin
			bank_frame[b] = -1;
		end
		repeat (16) @(posedge clk_133M);
		rst_133 <= 1'b1;
		fork
			run_camera();
			run_display();
		join
		repeat (8) @(posedge clk_133M);
		checks++;
		if (exp_q.size() != 0) begin
			report_error($sformatf("%0d display frame reads never reached the display",
				exp_q.size()));
		end
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- flist.f
hdl/fb_pkg.sv
hdl/cam_byte_pack.sv
hdl/pixel_fifo.sv
hdl/bank_rotator.sv
hdl/burst_scheduler.sv
hdl/frame_buffer_top.sv
test/sdram_burst_model.sv
test/tb_frame_buffer.sv
